/* l2cache.f */
verilog/l2cache_pkg.sv
verilog/bram_bytewrite.sv
verilog/l2cache_data.sv
verilog/l2cache_tag.sv
verilog/l2cache_plru.sv
verilog/l2cache_ctrl.sv
verilog/l2cache_top.sv
test/l2cache_tb_clock.sv
test/l2cache_mem_model.sv
test/l2cache_tb.sv

/* run_l2cache.sh */
#!/bin/sh
# Build the l2cache testbench with Verilator and run it

verilator --binary --timing --assert -Wno-fatal -f l2cache.f \
    --top-module l2cache_tb --Mdir obj_dir -o l2cache_sim || exit 1

out=$(./obj_dir/l2cache_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Testbench passed" && echo "PASS" || { echo "FAIL"; exit 1; }

/* test/l2cache_mem_model.sv */
module l2cache_mem_model (
    input  logic               clk,
    input  logic               mem_rd,
    input  logic               mem_wr,
    input  l2cache_pkg::addr_t mem_addr,
    input  l2cache_pkg::word_t mem_wdata,
    input  l2cache_pkg::strb_t mem_wstrb,
    output logic               mem_rvalid,
    output l2cache_pkg::line_t mem_rdata
);

    import l2cache_pkg::*;

    localparam int word_total = 2**addr_width / word_bytes;

    word_t words [word_total];

    // Fill pattern spread over every address bit
    function automatic word_t fill_word(int unsigned index);
        return (index * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic line_t read_line(addr_t addr);
        line_t line;
        for (int k = 0; k < line_bytes / word_bytes; k++) begin
            line[k*word_width +: word_width] = words[{addr[15:4], 2'(k)}];
        end
        return line;
    endfunction

    initial begin
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        for (int i = 0; i < word_total; i++) begin
            words[i] = fill_word(i);
        end
    end

    // Write port, byte selects honored
    always @(negedge clk) begin
        if (mem_wr) begin
            for (int b = 0; b < word_bytes; b++) begin
                if (mem_wstrb[b]) begin
                    words[mem_addr[15:2]][b*8 +: 8] = mem_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read port, answers 1 to 8 cycles after the fetch
    initial begin : read_port
        addr_t       line_addr;
        int unsigned latency;
        forever begin
            @(negedge clk);
            if (mem_rd) begin
                line_addr = mem_addr;
                latency   = 1 + $urandom_range(7);
                repeat (latency) @(posedge clk);
                #1;
                mem_rvalid = 1'b1;
                mem_rdata  = read_line(line_addr);
                @(posedge clk);
                #1;
                mem_rvalid = 1'b0;
            end
        end
    end

endmodule

/* test/l2cache_tb.sv */
module l2cache_tb;

    import l2cache_pkg::*;

    localparam int random_requests = 200;
    localparam int total_requests  = 20 + random_requests;
    localparam int timeout_cycles  = total_requests * 16 + 100;
    localparam int word_total      = 2**addr_width / word_bytes;

    logic  clk;
    logic  reset;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_strb;
    logic  resp_valid;
    line_t resp_rdata;
    logic  resp_hit;
    logic  mem_rd;
    logic  mem_wr;
    addr_t mem_addr;
    word_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_rvalid;
    line_t mem_rdata;

    // Reference memory and the last response
    word_t shadow [word_total];
    line_t got_line;
    logic  got_hit;

    l2cache_tb_clock clock_i (.clk);

    l2cache_mem_model mem_i (
        .clk, .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rvalid, .mem_rdata
    );

    l2cache_top dut_i (
        .clk, .reset,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_strb,
        .resp_valid, .resp_rdata, .resp_hit,
        .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rvalid, .mem_rdata
    );

    ////////////////////
    // Reference model
    ////////////////////

    // Same contents the memory model starts with
    function automatic word_t initial_word(int unsigned index);
        return (index * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic line_t shadow_line(addr_t addr);
        line_t line;
        for (int k = 0; k < line_bytes / word_bytes; k++) begin
            line[k*word_width +: word_width] = shadow[{addr[15:4], 2'(k)}];
        end
        return line;
    endfunction

    task automatic check_value(input string name, input line_t actual, input line_t expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %0h, expected %0h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first wrong value");
        end
    endtask

    // Issue one request and follow it cycle by cycle until the response
    task automatic do_request(input logic write, input addr_t addr, input word_t wdata,
                              input strb_t strb);
        int   cycle;
        int   rvalid_cycle;
        logic wr_seen;
        logic rd_seen;
        cycle        = 0;
        rvalid_cycle = -1;
        wr_seen      = 1'b0;
        rd_seen      = 1'b0;
        req_valid    = 1'b1;
        req_write    = write;
        req_addr     = addr;
        req_wdata    = wdata;
        req_strb     = strb;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        do begin
            @(negedge clk);
            cycle++;
            if (mem_wr) begin
                wr_seen = 1'b1;
                check_value("mem_wr cycle", line_t'(cycle), line_t'(1));
                check_value("mem_addr", line_t'(mem_addr), line_t'(addr & ~addr_t'(3)));
                check_value("mem_wdata", line_t'(mem_wdata), line_t'(wdata));
                check_value("mem_wstrb", line_t'(mem_wstrb), line_t'(strb));
            end
            if (mem_rd) begin
                rd_seen = 1'b1;
                check_value("mem_rd cycle", line_t'(cycle), line_t'(2));
                check_value("mem_addr", line_t'(mem_addr), line_t'(addr & ~addr_t'(15)));
            end
            if (mem_rvalid) begin
                rvalid_cycle = cycle;
            end
        end while (!resp_valid);
        got_line = resp_rdata;
        got_hit  = resp_hit;
        check_value("mem_wr", line_t'(wr_seen), line_t'(write));
        check_value("mem_rd", line_t'(rd_seen), line_t'(!write && !got_hit));
        if (write || got_hit) begin
            check_value("resp_valid cycle", line_t'(cycle), line_t'(2));
        end else begin
            check_value("resp_valid cycle", line_t'(cycle), line_t'(rvalid_cycle + 1));
        end
        if (write) begin
            for (int b = 0; b < word_bytes; b++) begin
                if (strb[b]) begin
                    shadow[addr[15:2]][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end else begin
            check_value("resp_rdata", got_line, shadow_line(addr));
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        addr_t       line_a;
        addr_t       line_b;
        addr_t       set_lines [5];
        addr_t       addr;
        int          misses;
        int unsigned slot;
        void'($urandom(68973));
        for (int i = 0; i < word_total; i++) begin
            shadow[i] = initial_word(i);
        end
        reset     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_strb  = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Cold read misses and the repeat hits
        line_a = 16'h1230;
        do_request(1'b0, line_a, '0, '0);
        check_value("resp_hit", line_t'(got_hit), line_t'(0));
        do_request(1'b0, line_a, '0, '0);
        check_value("resp_hit", line_t'(got_hit), line_t'(1));

        // Four lines of set 5 fill the empty ways
        for (int i = 0; i < 5; i++) begin
            set_lines[i] = {8'(8'h20 + i), 4'h5, 4'h0};
        end
        for (int i = 0; i < 4; i++) begin
            do_request(1'b0, set_lines[i], '0, '0);
            check_value("resp_hit", line_t'(got_hit), line_t'(0));
        end
        for (int i = 0; i < 4; i++) begin
            do_request(1'b0, set_lines[i], '0, '0);
            check_value("resp_hit", line_t'(got_hit), line_t'(1));
        end
        do_request(1'b0, set_lines[4], '0, '0);
        check_value("resp_hit", line_t'(got_hit), line_t'(0));

        // Newest first so the evicted line comes back last
        misses = 0;
        for (int i = 4; i >= 0; i--) begin
            do_request(1'b0, set_lines[i], '0, '0);
            if (i == 4) begin
                check_value("resp_hit", line_t'(got_hit), line_t'(1));
            end else if (!got_hit) begin
                misses++;
            end
        end
        check_value("misses in set 5", line_t'(misses), line_t'(1));

        // Store hit then a read back of the merged line
        addr = line_a | addr_t'($urandom_range(3) << 2);
        do_request(1'b1, addr, $urandom, 4'($urandom_range(15, 1)));
        check_value("resp_hit", line_t'(got_hit), line_t'(1));
        do_request(1'b0, line_a, '0, '0);
        check_value("resp_hit", line_t'(got_hit), line_t'(1));

        // Store miss goes only to memory
        line_b = 16'h7770;
        addr   = line_b | addr_t'($urandom_range(3) << 2);
        do_request(1'b1, addr, $urandom, 4'($urandom_range(15, 1)));
        check_value("resp_hit", line_t'(got_hit), line_t'(0));
        do_request(1'b0, line_b, '0, '0);
        check_value("resp_hit", line_t'(got_hit), line_t'(0));

        // Random traffic over 64 lines in sets 8 to 15
        for (int n = 0; n < random_requests; n++) begin
            slot = $urandom_range(63);
            addr = {8'(8'h40 + slot / 8), 4'(8 + slot % 8), 2'($urandom_range(3)), 2'b00};
            do_request(1'($urandom_range(1)), addr, $urandom, 4'($urandom));
        end

        $display("Testbench passed");
        $finish;
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("Testbench failed");
        $fatal(1, "Timeout, the requests did not complete within %0d cycles", timeout_cycles);
    end

endmodule

/* test/l2cache_tb_clock.sv */
module l2cache_tb_clock (
    output logic clk
);

    // Period of 4, first rising edge at 2
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

/* verilog/bram_bytewrite.sv */
module bram_bytewrite #(
    parameter int data_width = 128,
    parameter int addr_width = 4
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [addr_width-1:0]   waddr,
    input  logic [data_width-1:0]   din,
    input  logic [data_width/8-1:0] we,

    input  logic [addr_width-1:0]   raddr,
    output logic [data_width-1:0]   dout
);

    logic [data_width-1:0] mem [2**addr_width];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < data_width / 8; b++) begin
            if (we[b]) begin
                mem[waddr][b*8 +: 8] <= din[b*8 +: 8];
            end
        end
    end

    // One cycle read latency, old data on a same-address write
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

    addr_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(raddr) && (!(|we) || !$isunknown(waddr))
    );

endmodule

/* verilog/l2cache_ctrl.sv */
module l2cache_ctrl (
    input  logic                   clk,
    input  logic                   reset,

    // Upstream request and response
    input  logic                   req_valid,
    input  logic                   req_write,
    input  l2cache_pkg::addr_t     req_addr,
    input  l2cache_pkg::word_t     req_wdata,
    input  l2cache_pkg::strb_t     req_strb,
    output logic                   resp_valid,
    output l2cache_pkg::line_t     resp_rdata,
    output logic                   resp_hit,

    // Memory
    output logic                   mem_rd,
    output logic                   mem_wr,
    output l2cache_pkg::addr_t     mem_addr,
    output l2cache_pkg::word_t     mem_wdata,
    output l2cache_pkg::strb_t     mem_wstrb,
    input  logic                   mem_rvalid,
    input  l2cache_pkg::line_t     mem_rdata,

    // Arrays
    output l2cache_pkg::index_t    array_index,
    output l2cache_pkg::tag_t      lookup_tag,
    input  logic                   hit,
    input  l2cache_pkg::way_mask_t hit_way,
    input  l2cache_pkg::line_t [l2cache_pkg::way_count-1:0] lines_out,
    input  l2cache_pkg::way_mask_t victim_way,
    output l2cache_pkg::way_mask_t data_way_we,
    output logic                   data_replace,
    output l2cache_pkg::offset_t   data_word_offset,
    output l2cache_pkg::strb_t     data_byte_sel,
    output l2cache_pkg::word_t     data_din_word,
    output l2cache_pkg::line_t     data_din_line,
    output logic                   tag_fill_we,
    output l2cache_pkg::way_mask_t tag_fill_way,
    output logic                   plru_touch,
    output l2cache_pkg::way_mask_t plru_way
);

    import l2cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        write_q;
    addr_t       addr_q;
    word_t       wdata_q;
    strb_t       strb_q;
    line_t       resp_line_q;
    logic        resp_hit_q;
    logic        mem_rd_q;
    line_t       hit_line;
    logic        refill_done;
    logic        write_hit;

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            st_idle:    if (req_valid) state_next = st_compare;
            st_compare: state_next = (write_q || hit) ? st_respond : st_refill;
            st_refill:  if (mem_rvalid) state_next = st_respond;
            st_respond: state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            mem_rd_q <= 1'b0;
        end else begin
            state    <= state_next;
            // Read miss fetch goes out the cycle after the compare
            mem_rd_q <= (state == st_compare) && !write_q && !hit;
        end
    end

    // Request held until the response
    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) begin
            write_q <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            strb_q  <= req_strb;
        end
    end

    // One-hot way select of the read lines
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < way_count; w++) begin
            if (hit_way[w]) begin
                hit_line = hit_line | lines_out[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_compare) begin
            resp_line_q <= hit_line;
            resp_hit_q  <= hit;
        end else if (refill_done) begin
            resp_line_q <= mem_rdata;
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    assign refill_done = (state == st_refill) && mem_rvalid;
    assign write_hit   = (state == st_compare) && write_q && hit;

    // Arrays read straight from the request in the accept cycle
    assign array_index = (state == st_idle) ? req_addr[index_lsb +: index_width]
                                            : addr_q[index_lsb +: index_width];
    assign lookup_tag  = addr_q[tag_lsb +: tag_width];

    // Write-through on every store, hit or miss
    assign mem_wr    = (state == st_compare) && write_q;
    assign mem_rd    = mem_rd_q;
    assign mem_addr  = write_q ? (addr_q & ~addr_t'(word_bytes - 1))
                               : (addr_q & ~addr_t'(line_bytes - 1));
    assign mem_wdata = wdata_q;
    assign mem_wstrb = strb_q;

    assign data_way_we      = write_hit ? hit_way : (refill_done ? victim_way : '0);
    assign data_replace     = (state == st_refill);
    assign data_word_offset = addr_q[offset_lsb +: offset_width];
    assign data_byte_sel    = strb_q;
    assign data_din_word    = wdata_q;
    assign data_din_line    = mem_rdata;

    assign tag_fill_we  = refill_done;
    assign tag_fill_way = victim_way;

    assign plru_touch = ((state == st_compare) && hit) || refill_done;
    assign plru_way   = refill_done ? victim_way : hit_way;

    assign resp_valid = (state == st_respond);
    assign resp_rdata = resp_line_q;
    assign resp_hit   = resp_hit_q;

    // Requester waits for the response
    req_only_idle: assert property (
        @(posedge clk) disable iff (reset)
        req_valid |-> state == st_idle
    );

    // Memory answers only an outstanding fetch
    rvalid_in_refill: assert property (
        @(posedge clk) disable iff (reset)
        mem_rvalid |-> state == st_refill
    );

endmodule

/* verilog/l2cache_data.sv */
module l2cache_data (
    input  logic                   clk,
    input  logic                   reset,

    // Read side, one line per way
    input  l2cache_pkg::index_t    addr_read,
    output l2cache_pkg::line_t [l2cache_pkg::way_count-1:0] lines_out,

    // Write side
    input  l2cache_pkg::index_t    addr_write,
    input  l2cache_pkg::line_t     din_line,
    input  l2cache_pkg::word_t     din_word,
    input  l2cache_pkg::offset_t   word_offset,
    input  l2cache_pkg::strb_t     byte_sel,
    input  l2cache_pkg::way_mask_t way_we,
    input  logic                   replace
);

    import l2cache_pkg::*;

    logic [line_bytes-1:0] word_we;
    logic [line_bytes-1:0] line_we;
    line_t                 word_line;
    line_t                 din;

    ////////////////////
    // Enable and data steering
    ////////////////////

    always_comb begin
        // Four byte selects moved to the addressed word
        word_we = {{(line_bytes - word_bytes){1'b0}}, byte_sel}
                  << (int'(word_offset) * word_bytes);
        word_line = line_t'(din_word) << (int'(word_offset) * word_width);

        if (replace) begin
            // Whole line on refill
            line_we = '1;
            din     = din_line;
        end else begin
            line_we = word_we;
            din     = word_line;
        end
    end

    ////////////////////
    // Way RAMs
    ////////////////////

    for (genvar w = 0; w < way_count; w++) begin : g_way
        logic [line_bytes-1:0] way_byte_we;

        // Only the selected ways see the byte enables
        assign way_byte_we = way_we[w] ? line_we : '0;

        bram_bytewrite #(
            .data_width(line_width),
            .addr_width(index_width)
        ) way_ram_i (
            .clk  (clk),
            .reset(reset),

            .waddr(addr_write),
            .din  (din),
            .we   (way_byte_we),

            .raddr(addr_read),
            .dout (lines_out[w])
        );
    end

endmodule

/* verilog/l2cache_pkg.sv */
package l2cache_pkg;

    ////////////////////
    // Cache geometry
    ////////////////////

    localparam int way_count  = 4;
    localparam int set_count  = 16;
    localparam int line_bytes = 16;

    // Field widths
    localparam int addr_width   = 16;
    localparam int tag_width    = 8;
    localparam int index_width  = 4;
    localparam int offset_width = 2;
    localparam int word_width   = 32;
    localparam int word_bytes   = word_width / 8;
    localparam int line_width   = line_bytes * 8;

    // Address split: tag | index | word offset | byte
    localparam int offset_lsb = 2;
    localparam int index_lsb  = offset_lsb + offset_width;
    localparam int tag_lsb    = index_lsb + index_width;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [addr_width-1:0]   addr_t;
    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [index_width-1:0]  index_t;
    typedef logic [offset_width-1:0] offset_t;
    typedef logic [word_width-1:0]   word_t;
    typedef logic [word_bytes-1:0]   strb_t;
    typedef logic [line_width-1:0]   line_t;
    typedef logic [way_count-1:0]    way_mask_t;

    // Request FSM
    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_refill,
        st_respond
    } ctrl_state_t;

endpackage

/* verilog/l2cache_plru.sv */
module l2cache_plru (
    input  logic                   clk,
    input  logic                   reset,
    input  l2cache_pkg::index_t    index,
    input  logic                   touch,
    input  l2cache_pkg::way_mask_t touch_way,
    input  l2cache_pkg::way_mask_t valid_ways,
    output l2cache_pkg::way_mask_t victim_way
);

    import l2cache_pkg::*;

    // Bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
    logic [way_count-2:0] tree [set_count];
    logic [way_count-2:0] cur;
    way_mask_t            tree_way;

    assign cur = tree[index];

    always_comb begin
        tree_way = '0;
        if (!cur[0]) begin
            tree_way[{1'b0, cur[1]}] = 1'b1;
        end else begin
            tree_way[{1'b1, cur[2]}] = 1'b1;
        end

        // Empty ways first, lowest one wins
        victim_way = tree_way;
        for (int w = way_count - 1; w >= 0; w--) begin
            if (!valid_ways[w]) begin
                victim_way = way_mask_t'(1 << w);
            end
        end
    end

    // Point the tree away from the touched way
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < set_count; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            if (touch_way[0] || touch_way[1]) begin
                tree[index][0] <= 1'b1;
                tree[index][1] <= touch_way[0];
            end else begin
                tree[index][0] <= 1'b0;
                tree[index][2] <= touch_way[2];
            end
        end
    end

endmodule

/* verilog/l2cache_tag.sv */
module l2cache_tag (
    input  logic                   clk,
    input  logic                   reset,

    // Lookup, result one cycle after the index
    input  l2cache_pkg::index_t    lookup_index,
    input  l2cache_pkg::tag_t      lookup_tag,
    output logic                   hit,
    output l2cache_pkg::way_mask_t hit_way,
    output l2cache_pkg::way_mask_t valid_ways,

    // Fill on refill
    input  logic                   fill_we,
    input  l2cache_pkg::way_mask_t fill_way,
    input  l2cache_pkg::index_t    fill_index,
    input  l2cache_pkg::tag_t      fill_tag
);

    import l2cache_pkg::*;

    logic [way_count*tag_width-1:0] tags_out;
    way_mask_t                      tag_we;
    way_mask_t                      valid [set_count];
    way_mask_t                      valid_q;

    ////////////////////
    // Tag storage
    ////////////////////

    // One tag byte per way, the fill way picks the lane
    assign tag_we = fill_we ? fill_way : '0;

    bram_bytewrite #(
        .data_width(way_count * tag_width),
        .addr_width(index_width)
    ) tag_ram_i (
        .clk  (clk),
        .reset(reset),

        .waddr(fill_index),
        .din  ({way_count{fill_tag}}),
        .we   (tag_we),

        .raddr(lookup_index),
        .dout (tags_out)
    );

    // Valid flags
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < set_count; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_we) begin
            valid[fill_index] <= valid[fill_index] | fill_way;
        end
    end

    // Registered to line up with the tag RAM output
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid[lookup_index];
        end
    end

    ////////////////////
    // Compare
    ////////////////////

    always_comb begin
        for (int w = 0; w < way_count; w++) begin
            hit_way[w] = valid_q[w] && (tags_out[w*tag_width +: tag_width] == lookup_tag);
        end
    end

    assign hit        = |hit_way;
    assign valid_ways = valid_q;

    // A fill never lands on a way whose tag already matches
    hit_way_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(hit_way)
    );

endmodule

/* verilog/l2cache_top.sv */
module l2cache_top (
    input  logic               clk,
    input  logic               reset,

    input  logic               req_valid,
    input  logic               req_write,
    input  l2cache_pkg::addr_t req_addr,
    input  l2cache_pkg::word_t req_wdata,
    input  l2cache_pkg::strb_t req_strb,
    output logic               resp_valid,
    output l2cache_pkg::line_t resp_rdata,
    output logic               resp_hit,

    output logic               mem_rd,
    output logic               mem_wr,
    output l2cache_pkg::addr_t mem_addr,
    output l2cache_pkg::word_t mem_wdata,
    output l2cache_pkg::strb_t mem_wstrb,
    input  logic               mem_rvalid,
    input  l2cache_pkg::line_t mem_rdata
);

    import l2cache_pkg::*;

    index_t                   array_index;
    tag_t                     lookup_tag;
    logic                     hit;
    way_mask_t                hit_way;
    way_mask_t                valid_ways;
    way_mask_t                victim_way;
    line_t [way_count-1:0]    lines_out;
    way_mask_t                data_way_we;
    logic                     data_replace;
    offset_t                  data_word_offset;
    strb_t                    data_byte_sel;
    word_t                    data_din_word;
    line_t                    data_din_line;
    logic                     tag_fill_we;
    way_mask_t                tag_fill_way;
    logic                     plru_touch;
    way_mask_t                plru_way;

    l2cache_ctrl ctrl_i (
        .clk, .reset,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_strb,
        .resp_valid, .resp_rdata, .resp_hit,
        .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rvalid, .mem_rdata,
        .array_index, .lookup_tag, .hit, .hit_way, .lines_out, .victim_way,
        .data_way_we, .data_replace, .data_word_offset, .data_byte_sel,
        .data_din_word, .data_din_line, .tag_fill_we, .tag_fill_way,
        .plru_touch, .plru_way
    );

    // Read and write share the set index, one request at a time
    l2cache_data data_i (
        .clk, .reset,
        .addr_read  (array_index),
        .lines_out  (lines_out),
        .addr_write (array_index),
        .din_line   (data_din_line),
        .din_word   (data_din_word),
        .word_offset(data_word_offset),
        .byte_sel   (data_byte_sel),
        .way_we     (data_way_we),
        .replace    (data_replace)
    );

    l2cache_tag tag_i (
        .clk, .reset,
        .lookup_index(array_index),
        .lookup_tag  (lookup_tag),
        .hit         (hit),
        .hit_way     (hit_way),
        .valid_ways  (valid_ways),
        .fill_we     (tag_fill_we),
        .fill_way    (tag_fill_way),
        .fill_index  (array_index),
        .fill_tag    (lookup_tag)
    );

    l2cache_plru plru_i (
        .clk, .reset,
        .index     (array_index),
        .touch     (plru_touch),
        .touch_way (plru_way),
        .valid_ways(valid_ways),
        .victim_way(victim_way)
    );

endmodule
